// File: Makefile
# Verilator build for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
SIM_ARGS  ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/mem_subsys_properties.sv
`default_nettype none

module mem_subsys_properties (
  input wire clock,
  input wire arst_n,
  input wire req,
  input wire busy,
  input wire done,
  input wire rden,
  input wire wren,
  input wire complete_r,
  input wire complete_w
);

  timeunit 1ns;
  timeprecision 1ps;

  one_strobe: assert property (@(posedge clock) disable iff (!arst_n)
    !(rden && wren)) else $error("rden and wren high in the same cycle");

  read_pulse_in_strobe: assert property (@(posedge clock) disable iff (!arst_n)
    complete_r |-> rden) else $error("complete_r without rden");

  write_pulse_in_strobe: assert property (@(posedge clock) disable iff (!arst_n)
    complete_w |-> wren) else $error("complete_w without wren");

  // strobes held until their own completion
  rden_held: assert property (@(posedge clock) disable iff (!arst_n)
    rden && !complete_r |=> rden) else $error("rden dropped before complete_r");

  wren_held: assert property (@(posedge clock) disable iff (!arst_n)
    wren && !complete_w |=> wren) else $error("wren dropped before complete_w");

  done_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
    done |=> !done) else $error("done wider than one cycle");

  req_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
    req |-> !busy) else $error("req arrived while busy");

endmodule

bind mem_subsys_top mem_subsys_properties props0 (
  .clock      (clock),
  .arst_n     (arst_n),
  .req        (req),
  .busy       (busy),
  .done       (done),
  .rden       (mem_bus.rden),
  .wren       (mem_bus.wren),
  .complete_r (mem_bus.complete_r),
  .complete_w (mem_bus.complete_w)
);

`default_nettype wire

// File: dv/tb_mem_subsys.sv
`default_nettype none

module tb_mem_subsys import mem_bus_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LINE_ADDR_W = 8;
  localparam int INDEX_W     = 2;
  localparam int ADDR_W      = LINE_ADDR_W + WORD_OFS_W;
  localparam int NUM_WORDS   = 1 << ADDR_W;
  localparam int RANDOM_OPS  = 200;
  localparam int ACCESSES    = 2 + 3 + 16 + RANDOM_OPS;
  localparam int CYCLE_LIMIT = 40 * ACCESSES;

  localparam logic [31:0] SEED = 32'hdd35_ba8e;

  typedef logic [ADDR_W-1:0] addr_t;

  localparam addr_t      FIRST_ADDR       = {8'h03, 4'h5};
  localparam logic [7:0] EVICT_LINE_A     = 8'h10;   // index 0
  localparam logic [7:0] EVICT_LINE_B     = 8'h14;   // index 0, other tag
  localparam logic [7:0] RANDOM_BASE_LINE = 8'h40;

  logic  clock;
  logic  arst_n;
  logic  req;
  logic  we;
  addr_t word_addr;
  word_t wdata;
  logic  busy;
  logic  done;
  word_t rdata;

  word_t       sb_data    [NUM_WORDS];   // last value written per word
  bit          sb_written [NUM_WORDS];
  logic [31:0] lfsr;
  int          cycle_count = 0;

  mem_subsys_top #(
    .LINE_ADDR_W (LINE_ADDR_W),
    .INDEX_W     (INDEX_W)
  ) dut0 (
    .clock     (clock),
    .arst_n    (arst_n),
    .req       (req),
    .we        (we),
    .word_addr (word_addr),
    .wdata     (wdata),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("Simulation FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic release_reset;
    repeat (3) @(posedge clock);
    arst_n <= 1'b1;
  endtask

  // one request, then wait for done; cycles counts from the cycle after req
  task automatic access(input logic is_write, input addr_t addr, input word_t data,
                        output word_t rd, output int cycles);
    @(posedge clock);
    req       <= 1'b1;
    we        <= is_write;
    word_addr <= addr;
    wdata     <= data;
    @(negedge clock);
    compare("busy", 32'(busy), 32'd0);
    @(posedge clock);
    req    <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      compare("busy", 32'(busy), 32'd1);
    end while (!done);
    rd = rdata;
    if (is_write) begin
      sb_data[addr]    = data;
      sb_written[addr] = 1'b1;
    end
  endtask

  task automatic write_word(input addr_t addr, input word_t data, output int cycles);
    word_t unused;
    access(1'b1, addr, data, unused, cycles);
  endtask

  task automatic read_check(input addr_t addr, output int cycles);
    word_t rd;
    access(1'b0, addr, '0, rd, cycles);
    compare($sformatf("rdata@%03h", addr), rd, sb_data[addr]);
  endtask

  task automatic reset_idle_check;
    @(negedge clock);
    compare("busy", 32'(busy), 32'd0);
    compare("done", 32'(done), 32'd0);
    repeat (8) begin
      @(negedge clock);
      compare("busy", 32'(busy), 32'd0);
      compare("done", 32'(done), 32'd0);
    end
  endtask

  task automatic write_then_read;
    int cycles;
    write_word(FIRST_ADDR, 32'hcafe_0135, cycles);
    compare("miss_longer_than_hit", 32'(cycles > 2), 32'd1);   // cold miss fills
    read_check(FIRST_ADDR, cycles);
    compare("hit_cycles", 32'(cycles), 32'd2);
  endtask

  task automatic hit_latency;
    int cycles;
    read_check(FIRST_ADDR, cycles);
    compare("read_hit_cycles", 32'(cycles), 32'd2);
    write_word(FIRST_ADDR, 32'h0bad_f00d, cycles);
    compare("write_hit_cycles", 32'(cycles), 32'd2);
    read_check(FIRST_ADDR, cycles);
    compare("read_hit_cycles", 32'(cycles), 32'd2);
  endtask

  task automatic eviction_roundtrip;
    int cycles;
    for (int l = 0; l < 2; l++) begin
      for (int k = 0; k < 4; k++) begin
        logic [7:0] line_sel;
        addr_t      a;
        line_sel = (l == 0) ? EVICT_LINE_A : EVICT_LINE_B;
        a = {line_sel, 4'(k * 5)};
        write_word(a, 32'h5a00_0000 | 32'(a), cycles);
      end
    end
    // line A comes back from memory after B pushed it out
    for (int l = 0; l < 2; l++) begin
      for (int k = 0; k < 4; k++) begin
        logic [7:0] line_sel;
        addr_t      a;
        line_sel = (l == 0) ? EVICT_LINE_A : EVICT_LINE_B;
        a = {line_sel, 4'(k * 5)};
        read_check(a, cycles);
        if (k == 0) begin
          compare("refill_miss", 32'(cycles > 2), 32'd1);
        end
      end
    end
  endtask

  task automatic random_traffic;
    logic [31:0] op;
    logic [31:0] sel;
    logic [31:0] ofs;
    logic [31:0] data;
    logic [7:0]  line_sel;
    addr_t       a;
    int          cycles;
    int          reads;
    int          writes;
    reads  = 0;
    writes = 0;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      take_bits(1, op);
      take_bits(2, sel);
      take_bits(4, ofs);
      line_sel    = RANDOM_BASE_LINE;
      line_sel[2] = sel[1];   // tag bit
      line_sel[0] = sel[0];   // index bit
      a = {line_sel, ofs[3:0]};
      if (op[0] && sb_written[a]) begin
        read_check(a, cycles);
        reads++;
      end else begin
        take_bits(32, data);
        write_word(a, data, cycles);
        writes++;
      end
    end
    $display("random traffic: %0d reads, %0d writes", reads, writes);
  endtask

  initial begin
    clock     = 1'b0;
    arst_n    = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    word_addr = '0;
    wdata     = '0;
    lfsr      = SEED;
    release_reset();
    reset_idle_check();
    write_then_read();
    hit_latency();
    eviction_roundtrip();
    random_traffic();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  import mem_bus_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,   // dirty victim goes out
    FILL,        // requested line comes in
    RESPOND
  } cache_state_e;

  typedef logic [WORD_OFS_W-1:0] word_ofs_t;

  function automatic word_t get_word(line_t line, word_ofs_t ofs);
    return line[int'(ofs)*WORD_W +: WORD_W];
  endfunction

  function automatic line_t put_word(line_t line, word_ofs_t ofs, word_t data);
    line_t merged;
    merged = line;
    merged[int'(ofs)*WORD_W +: WORD_W] = data;
    return merged;
  endfunction

endpackage

`default_nettype wire

// File: rtl/line_cache.sv
`default_nettype none

module line_cache import mem_bus_pkg::*, cache_pkg::*; #(
  parameter int LINE_ADDR_W = 8,
  parameter int INDEX_W     = 2
) (
  input  wire                            clock,
  input  wire                            arst_n,
  input  wire                            req,
  input  wire                            we,
  input  wire [LINE_ADDR_W+WORD_OFS_W-1:0] word_addr,
  input  wire word_t                     wdata,
  output logic                           busy,
  output logic                           done,
  output word_t                          rdata,
  mem_line_if.master                     mem
);

  localparam int TAG_W  = LINE_ADDR_W - INDEX_W;
  localparam int SETS   = 1 << INDEX_W;
  localparam int ADDR_W = LINE_ADDR_W + WORD_OFS_W;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;

  cache_state_e state;
  cache_state_e next_state;

  // request held for the whole access
  logic              req_we;
  logic [ADDR_W-1:0] req_addr;
  word_t             req_wdata;

  tag_t      req_tag;
  index_t    req_index;
  word_ofs_t req_ofs;

  tag_t            tag_mem  [SETS];
  line_t           data_mem [SETS];
  logic [SETS-1:0] valid_q;
  logic [SETS-1:0] dirty_q;

  logic hit;
  logic victim_dirty;
  logic fill_done;

  assign req_ofs   = req_addr[WORD_OFS_W-1:0];
  assign req_index = req_addr[WORD_OFS_W +: INDEX_W];
  assign req_tag   = req_addr[WORD_OFS_W+INDEX_W +: TAG_W];

  assign hit          = valid_q[req_index] && (tag_mem[req_index] == req_tag);
  assign victim_dirty = valid_q[req_index] && dirty_q[req_index];
  assign fill_done    = (state == FILL) && mem.complete_r;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (req) begin
          next_state = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          next_state = RESPOND;
        end else if (victim_dirty) begin
          next_state = WRITEBACK;
        end else begin
          next_state = FILL;   // clean or empty slot, just overwrite
        end
      end
      WRITEBACK: begin
        if (mem.complete_w) begin
          next_state = FILL;
        end
      end
      FILL: begin
        if (mem.complete_r) begin
          next_state = RESPOND;
        end
      end
      RESPOND: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // line status bits
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (state == LOOKUP && hit && req_we) begin
        dirty_q[req_index] <= 1'b1;
      end
      if (fill_done) begin
        valid_q[req_index] <= 1'b1;
        dirty_q[req_index] <= req_we;   // pending write lands below
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && req) begin
      req_we    <= we;
      req_addr  <= word_addr;
      req_wdata <= wdata;
    end
    if (state == LOOKUP && hit && req_we) begin
      data_mem[req_index] <= put_word(data_mem[req_index], req_ofs, req_wdata);
    end
    if (fill_done) begin
      tag_mem[req_index] <= req_tag;
      if (req_we) begin
        data_mem[req_index] <= put_word(mem.rd, req_ofs, req_wdata);
      end else begin
        data_mem[req_index] <= mem.rd;
      end
    end
  end

  assign busy  = (state != IDLE);
  assign done  = (state == RESPOND);
  assign rdata = get_word(data_mem[req_index], req_ofs);

  // victim address during writeback, requested line otherwise
  assign mem.rden      = (state == FILL);
  assign mem.wren      = (state == WRITEBACK);
  assign mem.line_addr = (state == WRITEBACK) ? {tag_mem[req_index], req_index}
                                              : {req_tag, req_index};
  assign mem.wd        = data_mem[req_index];

endmodule

`default_nettype wire

// File: rtl/line_mem.sv
`default_nettype none

module line_mem import mem_bus_pkg::*; #(
  parameter int LINE_ADDR_W = 8
) (
  input wire        clock,
  input wire        arst_n,
  mem_line_if.slave mem
);

  localparam int BYTE_ADDR_W = LINE_ADDR_W + WORD_OFS_W + BYTE_OFS_W;
  localparam int DEPTH       = (1 << LINE_ADDR_W) * BYTES_PER_LINE;

  byte_t ram [DEPTH];

  logic [1:0] phase;
  logic [1:0] next_phase;
  logic       complete_r_q;
  logic       complete_w_q;
  line_t      rd_q;

  function automatic logic [BYTE_ADDR_W-1:0] byte_addr(
    logic [LINE_ADDR_W-1:0] line,
    int                     w,
    int                     b
  );
    return {line, WORD_OFS_W'(w), BYTE_OFS_W'(b)};
  endfunction

  assign next_phase = phase + 2'd1;   // free-running, wraps 3 -> 0

  // completion fires as the counter rolls into phase one
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      phase        <= 2'd0;
      complete_r_q <= 1'b0;
      complete_w_q <= 1'b0;
    end else begin
      phase        <= next_phase;
      complete_r_q <= (next_phase == 2'd1) && mem.rden;
      complete_w_q <= (next_phase == 2'd1) && mem.wren;
    end
  end

  // whole line read, bytes little-endian within each word
  always_ff @(posedge clock) begin
    if (mem.rden) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
          rd_q[w*WORD_W + b*BYTE_W +: BYTE_W] <= ram[byte_addr(mem.line_addr, w, b)];
        end
      end
    end
  end

  // rewritten every cycle the strobe is held
  always_ff @(posedge clock) begin
    if (mem.wren) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
          ram[byte_addr(mem.line_addr, w, b)] <= mem.wd[w*WORD_W + b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  assign mem.rd         = rd_q;
  assign mem.complete_r = complete_r_q;
  assign mem.complete_w = complete_w_q;

endmodule

`default_nettype wire

// File: rtl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  localparam int WORD_W         = 32;
  localparam int BYTE_W         = 8;
  localparam int WORDS_PER_LINE = 16;
  localparam int WORD_OFS_W     = 4;   // log2 of WORDS_PER_LINE
  localparam int BYTES_PER_WORD = WORD_W / BYTE_W;
  localparam int BYTE_OFS_W     = 2;   // log2 of BYTES_PER_WORD
  localparam int BYTES_PER_LINE = WORDS_PER_LINE * BYTES_PER_WORD;
  localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BYTE_W-1:0] byte_t;

  // word w of a line sits at bits 32w+31 down to 32w
  typedef logic [LINE_W-1:0] line_t;

endpackage

`default_nettype wire

// File: rtl/mem_line_if.sv
`default_nettype none

interface mem_line_if import mem_bus_pkg::*; #(
  parameter int LINE_ADDR_W = 8
);

  logic                   rden;        // held until complete_r
  logic                   wren;        // held until complete_w
  logic [LINE_ADDR_W-1:0] line_addr;
  line_t                  wd;
  line_t                  rd;          // valid with complete_r
  logic                   complete_r;
  logic                   complete_w;

  modport master (
    output rden,
    output wren,
    output line_addr,
    output wd,
    input  rd,
    input  complete_r,
    input  complete_w
  );

  modport slave (
    input  rden,
    input  wren,
    input  line_addr,
    input  wd,
    output rd,
    output complete_r,
    output complete_w
  );

endinterface

`default_nettype wire

// File: rtl/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top import mem_bus_pkg::*; #(
  parameter int LINE_ADDR_W = 8,   // 256 lines
  parameter int INDEX_W     = 2    // 4 cache lines
) (
  input  wire                              clock,
  input  wire                              arst_n,
  input  wire                              req,
  input  wire                              we,
  input  wire [LINE_ADDR_W+WORD_OFS_W-1:0] word_addr,
  input  wire word_t                       wdata,
  output logic                             busy,
  output logic                             done,
  output word_t                            rdata
);

  mem_line_if #(
    .LINE_ADDR_W (LINE_ADDR_W)
  ) mem_bus ();

  line_cache #(
    .LINE_ADDR_W (LINE_ADDR_W),
    .INDEX_W     (INDEX_W)
  ) cache0 (
    .clock     (clock),
    .arst_n    (arst_n),
    .req       (req),
    .we        (we),
    .word_addr (word_addr),
    .wdata     (wdata),
    .busy      (busy),
    .done      (done),
    .rdata     (rdata),
    .mem       (mem_bus.master)
  );

  line_mem #(
    .LINE_ADDR_W (LINE_ADDR_W)
  ) mem0 (
    .clock  (clock),
    .arst_n (arst_n),
    .mem    (mem_bus.slave)
  );

endmodule

`default_nettype wire

// File: sources.f
rtl/mem_bus_pkg.sv
rtl/cache_pkg.sv
rtl/mem_line_if.sv
rtl/line_mem.sv
rtl/line_cache.sv
rtl/mem_subsys_top.sv
dv/mem_subsys_properties.sv
dv/tb_mem_subsys.sv
